// ==== gameTypes.sv ====
//**********************************************************
// Screen-wide types shared by every game object: pixel
// coordinates, colour, collision flags and keyboard scans.
//**********************************************************
`default_nettype none

package gameTypes;

    localparam int SCREEN_W = 640; // visible width in pixels.
    localparam int SCREEN_H = 480; // visible height in pixels.

    typedef logic [10:0] coordT; // unsigned screen coordinate.
    typedef logic [7:0]  rgbT;   // RRRGGGBB.

    // hit flags reported by the collision logic of the game.
    typedef struct packed {
        logic playerHit;  // ship was struck.
        logic missileHit; // our missile struck something.
    } collisionT;

    // one keyboard scan event, make and brake are single-cycle strobes.
    typedef struct packed {
        logic [7:0] code;
        logic       make;
        logic       brake;
    } scanT;

    // held state of the keys the player reacts to.
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
    } keyFlagsT;

endpackage

`default_nettype wire

// ==== playerParams.sv ====
//**********************************************************
// Player constants: ship and missile sizes, speeds, key
// codes, lives bar layout and frame counts.
//**********************************************************
`default_nettype none

package playerParams;

    localparam int PLAYER_W       = 32;
    localparam int PLAYER_H       = 32;
    localparam int PLAYER_START_X = 304; // centred horizontally.
    localparam int PLAYER_START_Y = 420;
    localparam int PLAYER_SPEED   = 4;   // pixels per frame per axis.
    localparam logic [7:0] PLAYER_RGB = 8'h1C;

    localparam logic [7:0] KEY_UP    = 8'h75; // keypad 8.
    localparam logic [7:0] KEY_DOWN  = 8'h72; // keypad 2.
    localparam logic [7:0] KEY_LEFT  = 8'h6B; // keypad 4.
    localparam logic [7:0] KEY_RIGHT = 8'h74; // keypad 6.
    localparam logic [7:0] KEY_FIRE  = 8'h29; // space bar.

    localparam int LIVES_MAX       = 3;
    localparam int LIVES_W         = 2;
    localparam int DAMAGED_FRAMES  = 8;
    localparam int COOLDOWN_FRAMES = 6;

    localparam int MISSILE_W        = 4;
    localparam int MISSILE_H        = 8;
    localparam int MISSILE_SPEED    = 8;  // pixels per frame, upwards.
    localparam int MISSILE_X_OFFSET = 14; // centres it on the ship nose.
    localparam logic [7:0] MISSILE_RGB = 8'hFC;

    localparam int LIVES_ICON = 8; // icons are square.
    localparam int LIVES_GAP  = 4;
    localparam int LIVES_X    = 8;
    localparam int LIVES_Y    = 8;
    localparam logic [7:0] LIVES_RGB = 8'hE0;

endpackage

`default_nettype wire

// ==== playerControls.sv ====
//**********************************************************
// Keyboard decoder for the player. Turns make/brake scan
// strobes into one held flag per control key.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module playerControls
    import gameTypes::*, playerParams::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  scanT     scan,
    output keyFlagsT keys
);

    // a make and a brake together cancel, so only one strobe alone acts.
    logic strobe;

    assign strobe = scan.make ^ scan.brake;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            keys <= '0;
        end else if (strobe) begin
            case (scan.code)
                KEY_UP:    keys.up    <= scan.make;
                KEY_DOWN:  keys.down  <= scan.make;
                KEY_LEFT:  keys.left  <= scan.make;
                KEY_RIGHT: keys.right <= scan.make;
                KEY_FIRE:  keys.fire  <= scan.make;
                default:   keys       <= keys; // unknown code, ignore.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== playerMotion.sv ====
//**********************************************************
// Ship position. Steps once per frame tick from the held
// direction keys and stays clamped inside the screen.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module playerMotion
    import gameTypes::*, playerParams::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     frameTick,
    input  keyFlagsT keys,
    output coordT    shipX,
    output coordT    shipY
);

    coordT nextX;
    coordT nextY;

    // one axis step, opposite keys cancel and the result is clamped.
    function automatic coordT stepAxis(input coordT pos, input logic inc,
                                       input logic dec, input int maxPos);
        int p;
        p = int'(pos);
        if (inc && !dec) p = p + PLAYER_SPEED;
        else if (dec && !inc) p = p - PLAYER_SPEED;
        if (p < 0) p = 0;
        else if (p > maxPos) p = maxPos;
        return coordT'(p);
    endfunction

    assign nextX = stepAxis(shipX, keys.right, keys.left, SCREEN_W - PLAYER_W);
    assign nextY = stepAxis(shipY, keys.down, keys.up, SCREEN_H - PLAYER_H); // y grows down.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            shipX <= coordT'(PLAYER_START_X);
            shipY <= coordT'(PLAYER_START_Y);
        end else if (frameTick) begin
            shipX <= nextX;
            shipY <= nextY;
        end
    end

    // ship must always sit fully on screen.
    assert property (@(posedge clk) disable iff (!rstN)
        shipX <= SCREEN_W - PLAYER_W && shipY <= SCREEN_H - PLAYER_H);

endmodule

`default_nettype wire

// ==== playerLives.sv ====
//**********************************************************
// Life counter of the ship. A hit costs a life and opens a
// damaged window in which the ship flickers and is immune.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module playerLives
    import playerParams::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               frameTick,
    input  logic               hit,
    output logic [LIVES_W-1:0] livesLeft,
    output logic               damaged,
    output logic               hidden,
    output logic               dead
);

    logic [$clog2(DAMAGED_FRAMES+1)-1:0] dmgCount; // frame ticks left in the window.
    logic takeHit;

    assign takeHit = hit && !damaged && !dead;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            livesLeft <= LIVES_W'(LIVES_MAX);
            damaged   <= 1'b0;
            hidden    <= 1'b0;
            dead      <= 1'b0;
            dmgCount  <= '0;
        end else if (takeHit) begin
            livesLeft <= livesLeft - 1'b1;
            damaged   <= 1'b1;
            dmgCount  <= ($clog2(DAMAGED_FRAMES+1))'(DAMAGED_FRAMES);
            if (livesLeft == 1) dead <= 1'b1; // last life gone and dead sticks until reset.
        end else if (frameTick && damaged) begin
            // the window length is even so hidden lands back on 0.
            hidden   <= ~hidden;
            dmgCount <= dmgCount - 1'b1;
            if (dmgCount == 1) damaged <= 1'b0;
        end
    end

    // lives never rise above the reset count of LIVES_MAX.
    assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> livesLeft <= $past(livesLeft));

    // dead only clears through reset.
    assert property (@(posedge clk) $past(rstN) && $past(dead) |-> dead);

endmodule

`default_nettype wire

// ==== playerWeapon.sv ====
//**********************************************************
// Player gun. Launches a single missile under a frame
// cooldown, flies it upwards and removes it on a hit or at
// the top of the screen.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module playerWeapon
    import gameTypes::*, playerParams::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  frameTick,
    input  logic  fire,
    input  logic  damaged,
    input  logic  missileHit,
    input  coordT shipX,
    input  coordT shipY,
    output logic  missileOn,
    output coordT missileX,
    output coordT missileY
);

    localparam int CD_W = $clog2(COOLDOWN_FRAMES + 1);

    logic [CD_W-1:0] cooldown;
    logic            launch;
    coordT           launchY;

    assign launch = frameTick && fire && !damaged && cooldown == '0 && !missileOn;

    // saturate so a ship at the very top cannot wrap the missile.
    assign launchY = (shipY >= MISSILE_H) ? shipY - coordT'(MISSILE_H) : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cooldown <= '0;
        end else if (launch) begin
            cooldown <= CD_W'(COOLDOWN_FRAMES);
        end else if (frameTick && cooldown != '0) begin
            cooldown <= cooldown - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            missileOn <= 1'b0;
            missileX  <= '0;
            missileY  <= '0;
        end else if (missileOn) begin
            if (missileHit) begin
                missileOn <= 1'b0;
            end else if (frameTick) begin
                if (missileY < MISSILE_SPEED) missileOn <= 1'b0; // left the screen.
                else missileY <= missileY - coordT'(MISSILE_SPEED);
            end
        end else if (launch) begin
            missileOn <= 1'b1;
            missileX  <= shipX + coordT'(MISSILE_X_OFFSET);
            missileY  <= launchY;
        end
    end

    // every new missile comes from an idle gun and restarts the cooldown.
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(missileOn) |-> $past(cooldown) == '0 && cooldown == CD_W'(COOLDOWN_FRAMES));

endmodule

`default_nettype wire

// ==== playerRenderer.sv ====
//**********************************************************
// Pixel renderer of the player objects. Registered draw
// requests and colour, one cycle after the pixel position.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module playerRenderer
    import gameTypes::*, playerParams::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  coordT              pixelX,
    input  coordT              pixelY,
    input  coordT              shipX,
    input  coordT              shipY,
    input  logic               hidden,
    input  logic               missileOn,
    input  coordT              missileX,
    input  coordT              missileY,
    input  logic [LIVES_W-1:0] livesLeft,
    output logic               playerDR,
    output logic               missileDR,
    output logic               livesDR,
    output rgbT                pixelRGB
);

    logic shipIn;
    logic missileIn;
    logic livesIn;

    function automatic logic inRect(input coordT px, input coordT py, input int x,
                                    input int y, input int w, input int h);
        return px >= x && px < x + w && py >= y && py < y + h;
    endfunction

    assign shipIn    = !hidden && inRect(pixelX, pixelY, shipX, shipY, PLAYER_W, PLAYER_H);
    assign missileIn = missileOn
                       && inRect(pixelX, pixelY, missileX, missileY, MISSILE_W, MISSILE_H);

    // one icon per remaining life, left to right.
    always_comb begin
        livesIn = 1'b0;
        for (int i = 0; i < LIVES_MAX; i++) begin
            if (i < livesLeft && inRect(pixelX, pixelY, LIVES_X + i * (LIVES_ICON + LIVES_GAP),
                                        LIVES_Y, LIVES_ICON, LIVES_ICON)) begin
                livesIn = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            playerDR  <= 1'b0;
            missileDR <= 1'b0;
            livesDR   <= 1'b0;
            pixelRGB  <= '0;
        end else begin
            playerDR  <= shipIn;
            missileDR <= missileIn;
            livesDR   <= livesIn;
            if (shipIn) pixelRGB <= PLAYER_RGB; // ship wins over the rest.
            else if (missileIn) pixelRGB <= MISSILE_RGB;
            else if (livesIn) pixelRGB <= LIVES_RGB;
            else pixelRGB <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== player.sv ====
//**********************************************************
// Player top level. Connects key decoding, motion, lives,
// weapon and the pixel renderer behind one frame tick.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module player
    import gameTypes::*, playerParams::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      enable,
    input  scanT      scan,
    input  logic      startOfFrame,
    input  coordT     pixelX,
    input  coordT     pixelY,
    input  collisionT collision,
    output logic      playerDR,
    output logic      missileDR,
    output logic      livesDR,
    output rgbT       pixelRGB,
    output logic      dead
);

    logic               frameTick;
    keyFlagsT           keys;
    coordT              shipX;
    coordT              shipY;
    logic [LIVES_W-1:0] livesLeft;
    logic               damaged;
    logic               hidden;
    logic               missileOn;
    coordT              missileX;
    coordT              missileY;

    assign frameTick = startOfFrame & enable; // game paused when enable is low.

    playerControls playerControls_inst (.clk(clk), .rstN(rstN), .scan(scan), .keys(keys));

    playerMotion playerMotion_inst (
        .clk(clk), .rstN(rstN), .frameTick(frameTick), .keys(keys),
        .shipX(shipX), .shipY(shipY)
    );

    playerLives playerLives_inst (
        .clk(clk), .rstN(rstN), .frameTick(frameTick), .hit(collision.playerHit),
        .livesLeft(livesLeft), .damaged(damaged), .hidden(hidden), .dead(dead)
    );

    playerWeapon playerWeapon_inst (
        .clk(clk), .rstN(rstN), .frameTick(frameTick), .fire(keys.fire),
        .damaged(damaged), .missileHit(collision.missileHit),
        .shipX(shipX), .shipY(shipY),
        .missileOn(missileOn), .missileX(missileX), .missileY(missileY)
    );

    playerRenderer playerRenderer_inst (
        .clk(clk), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY),
        .shipX(shipX), .shipY(shipY), .hidden(hidden),
        .missileOn(missileOn), .missileX(missileX), .missileY(missileY),
        .livesLeft(livesLeft), .playerDR(playerDR), .missileDR(missileDR),
        .livesDR(livesDR), .pixelRGB(pixelRGB)
    );

endmodule

`default_nettype wire

// ==== tbPlayer.sv ====
//**********************************************************
// Testbench for the player block. Replays the pattern file
// line by line and checks every probe against its values.
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module tbPlayer
    import gameTypes::*;
();

    localparam int CLK_HALF = 2; // 4 ns period.

    logic      clk;
    logic      rstN;
    logic      enable;
    scanT      scan;
    logic      startOfFrame;
    coordT     pixelX;
    coordT     pixelY;
    collisionT collision;
    logic      playerDR;
    logic      missileDR;
    logic      livesDR;
    rgbT       pixelRGB;
    logic      dead;

    int            fd;
    int            got;
    int            lineCount;
    logic          counted;
    logic [127:0]  testName;  // first token of a pattern line.
    logic [63:0]   opName;
    logic [2047:0] skipLine;
    logic [31:0]   arg [6];

    player player_inst (
        .clk(clk), .rstN(rstN), .enable(enable), .scan(scan),
        .startOfFrame(startOfFrame), .pixelX(pixelX), .pixelY(pixelY),
        .collision(collision), .playerDR(playerDR), .missileDR(missileDR),
        .livesDR(livesDR), .pixelRGB(pixelRGB), .dead(dead)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // one rising edge and the 1 ns hold before inputs change.
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %0s, %0s: expected %0h, actual %0h",
                     testName, what, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic readArgs(input int count);
        int n;
        for (int i = 0; i < count; i++) begin
            n = $fscanf(fd, "%h", arg[i]);
            if (n != 1) begin
                $display("pattern line %0s has too few fields", testName);
                $display("sim failed");
                $fatal(1);
            end
        end
    endtask

    task automatic sendKey(input logic [7:0] code, input logic isMake);
        scan.code  = code;
        scan.make  = isMake;
        scan.brake = !isMake; // single-cycle strobe.
        nextCycle();
        scan = '0;
    endtask

    // each tick is one cycle of startOfFrame followed by an idle cycle.
    task automatic frameTicks(input int count, input logic en);
        for (int i = 0; i < count; i++) begin
            enable       = en;
            startOfFrame = 1'b1;
            nextCycle();
            startOfFrame = 1'b0;
            enable       = 1'b1;
            nextCycle();
        end
    endtask

    task automatic pulseHit(input logic [1:0] bits);
        collision = bits;
        nextCycle();
        collision = '0;
    endtask

    task automatic probePixel();
        pixelX = coordT'(arg[0]);
        pixelY = coordT'(arg[1]);
        nextCycle(); // renderer latency is one cycle.
        checkValue("playerDR", arg[2], 32'(playerDR));
        checkValue("missileDR", arg[3], 32'(missileDR));
        checkValue("livesDR", arg[4], 32'(livesDR));
        checkValue("pixelRGB", arg[5], 32'(pixelRGB));
    endtask

    // watchdog sized from the pattern count.
    initial begin
        wait (counted === 1'b1);
        repeat (200 * lineCount + 1000) @(posedge clk);
        $display("timeout: patterns did not finish within %0d cycles", 200 * lineCount + 1000);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        rstN         = 1'b0;
        enable       = 1'b0;
        scan         = '0;
        startOfFrame = 1'b0;
        pixelX       = '0;
        pixelY       = '0;
        collision    = '0;
        lineCount    = 0;
        counted      = 1'b0;
        fd = $fopen("playerPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file playerPatterns.txt");
            $display("sim failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            if ($fgets(skipLine, fd) != 0) lineCount++;
        end
        $fclose(fd);
        counted = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rstN   = 1'b1;
        enable = 1'b1;
        fd = $fopen("playerPatterns.txt", "r");
        while ($fscanf(fd, "%s", testName) == 1) begin
            if (testName == 128'("#")) begin
                got = $fgets(skipLine, fd); // comment line.
            end else begin
                got = $fscanf(fd, "%s", opName);
                if (got != 1) begin
                    $display("pattern line %0s has no opcode", testName);
                    $display("sim failed");
                    $fatal(1);
                end
                case (opName)
                    64'("KEY"): begin
                        readArgs(2);
                        sendKey(arg[0][7:0], arg[1][0]);
                    end
                    64'("FRAMES"): begin
                        readArgs(1);
                        frameTicks(int'(arg[0]), 1'b1);
                    end
                    64'("NOEN"): begin
                        readArgs(1);
                        frameTicks(int'(arg[0]), 1'b0);
                    end
                    64'("HIT"): begin
                        readArgs(1);
                        pulseHit(arg[0][1:0]);
                    end
                    64'("PROBE"): begin
                        readArgs(6);
                        probePixel();
                    end
                    64'("DEAD"): begin
                        readArgs(1);
                        checkValue("dead", arg[0], 32'(dead));
                    end
                    default: begin
                        $display("pattern line %0s has an unknown opcode", testName);
                        $display("sim failed");
                        $fatal(1);
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== playerPatterns.txt ====
# columns: name opcode fields, all numbers hex
# KEY code make | FRAMES n | NOEN n | HIT bits(2=ship,1=missile) | PROBE x y dr mdr ldr rgb | DEAD exp
reset PROBE 130 1A4 1 0 0 1C
icon1 PROBE 8 8 0 0 1 E0
icon2 PROBE 14 8 0 0 1 E0
icon3 PROBE 20 8 0 0 1 E0
icon4 PROBE 2C 8 0 0 0 0
rightOn KEY 74 1
right5 FRAMES 5
rightOff KEY 74 0
newEdge PROBE 144 1A4 1 0 0 1C
oldEdge PROBE 130 1A4 0 0 0 0
pauseOn KEY 74 1
paused NOEN 3
pauseOff KEY 74 0
noMove PROBE 144 1A4 1 0 0 1C
leftOn KEY 6B 1
leftRun FRAMES 5A
leftOff KEY 6B 0
clampX PROBE 0 1A4 1 0 0 1C
clampEdge PROBE 20 1A4 0 0 0 0
fireOn KEY 29 1
shot FRAMES 1
launch PROBE E 19C 0 1 0 FC
fly FRAMES 2
flight PROBE E 18C 0 1 0 FC
mHit HIT 1
removed PROBE E 18C 0 0 0 0
cool FRAMES 1
noShot PROBE E 19C 0 0 0 0
fireOff KEY 29 0
hit1 HIT 2
bar2 PROBE 20 8 0 0 0 0
icon2b PROBE 14 8 0 0 1 E0
shown PROBE 0 1A4 1 0 0 1C
flick1 FRAMES 1
hiddenShip PROBE 0 1A4 0 0 0 0
flick2 FRAMES 1
shown2 PROBE 0 1A4 1 0 0 1C
immune HIT 2
still2 PROBE 14 8 0 0 1 E0
window FRAMES 6
hit2 HIT 2
alive DEAD 0
window2 FRAMES 8
hit3 HIT 2
bar0 PROBE 8 8 0 0 0 0
isDead DEAD 1
rest FRAMES 8
late HIT 2
stillDead DEAD 1
stillBar0 PROBE 8 8 0 0 0 0

// ==== all.f ====
gameTypes.sv
playerParams.sv
playerControls.sv
playerMotion.sv
playerLives.sv
playerWeapon.sv
playerRenderer.sv
player.sv
tbPlayer.sv

// ==== run.sh ====
#!/bin/sh
# Builds the player testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f all.f --top-module tbPlayer
./obj_dir/VtbPlayer > sim.log 2>&1 || true
cat sim.log
grep -q "sim passed" sim.log
